//--- run_sim.sh
#!/bin/sh
# Builds the shim testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_shim_tb -f sim.f

status=0
./obj_dir/Vmem_shim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished cleanly"

//--- sim.f
source/cci_req_pkg.sv
source/shim_cfg_pkg.sv
source/cci_tx_if.sv
source/shim_fifo.sv
source/shim_buffer_lockstep.sv
source/req_issue_apb.sv
source/host_mem_apb.sv
source/mem_shim_top.sv
tests/mem_shim_asserts.sv
tests/mem_shim_tb.sv

//--- source/cci_req_pkg.sv
/*
 * Request and response field types shared by the buffer, the issue stage
 * and the memory model
 */
`default_nettype none

package cci_req_pkg;

    // Word address, so consecutive addresses name consecutive 32-bit words
    typedef logic [15:0] t_addr;

    // One data word as carried on APB and on the response
    typedef logic [31:0] t_data;

    // Request tag, returned unchanged with the read response
    typedef logic [7:0] t_tag;

    // Kind of APB transfer currently being issued
    typedef enum logic
    {
        xfer_read  = 1'b0,
        xfer_write = 1'b1
    } t_xfer_kind;

endpackage

`default_nettype wire

//--- source/cci_tx_if.sv
/*
 * One lockstep request entry holding both channels, passed from the buffer
 * to the issue stage together with the dequeue strobe
 */
`timescale 1ns/1ns
`default_nettype none

interface cci_tx_if;

    // Channel 0 carries read requests
    logic                 c0_valid;
    cci_req_pkg::t_addr   c0_addr;
    cci_req_pkg::t_tag    c0_tag;

    // Channel 1 carries write requests
    logic                 c1_valid;
    cci_req_pkg::t_addr   c1_addr;
    cci_req_pkg::t_data   c1_data;
    cci_req_pkg::t_tag    c1_tag;

    // Removes the whole entry, both channels at once
    logic                 deq;

    modport producer
    (
        output c0_valid, c0_addr, c0_tag,
        output c1_valid, c1_addr, c1_data, c1_tag,
        input  deq
    );

    modport consumer
    (
        input  c0_valid, c0_addr, c0_tag,
        input  c1_valid, c1_addr, c1_data, c1_tag,
        output deq
    );

endinterface

`default_nettype wire

//--- source/host_mem_apb.sv
/*
 * APB completer modelling host memory as an array of words, one wait
 * state per transfer, contents zeroed by reset
 */
`timescale 1ns/1ns
`default_nettype none

module host_mem_apb
#(
    parameter int MEM_WORDS = shim_cfg_pkg::DEF_MEM_WORDS
)
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               psel,
    input  wire logic               penable,
    input  wire logic               pwrite,
    input  cci_req_pkg::t_addr      paddr,
    input  cci_req_pkg::t_data      pwdata,
    output cci_req_pkg::t_data      prdata,
    output logic                    pready
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    cci_req_pkg::t_data mem [MEM_WORDS];
    logic [IDX_W-1:0]   word_idx;
    logic               access;
    logic               wait_done;

    // Addresses beyond the array fold back onto it
    assign word_idx = IDX_W'(paddr % cci_req_pkg::t_addr'(MEM_WORDS));

    // The first access cycle waits, the second one completes
    assign access = psel && penable;
    assign pready = access && wait_done;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wait_done <= 1'b0;
        end
        else
        begin
            wait_done <= access && !wait_done;
        end
    end

    // Memory starts out as all zeros and takes writes on completion only
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (pready && pwrite)
        begin
            mem[word_idx] <= pwdata;
        end
    end

    assign prdata = mem[word_idx];

endmodule

`default_nettype wire

//--- source/mem_shim_top.sv
/*
 * Memory request shim: lockstep buffer, APB issue stage and host memory
 * chained in that order behind plain accelerator-side ports
 */
`timescale 1ns/1ns
`default_nettype none

module mem_shim_top
#(
    parameter int N_ENTRIES = shim_cfg_pkg::DEF_N_ENTRIES,
    parameter int THRESHOLD = shim_cfg_pkg::DEF_THRESHOLD,
    parameter int MEM_WORDS = shim_cfg_pkg::DEF_MEM_WORDS
)
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               c0_valid,
    input  cci_req_pkg::t_addr      c0_addr,
    input  cci_req_pkg::t_tag       c0_tag,
    input  wire logic               c1_valid,
    input  cci_req_pkg::t_addr      c1_addr,
    input  cci_req_pkg::t_data      c1_data,
    input  cci_req_pkg::t_tag       c1_tag,
    output logic                    almost_full,
    output logic                    rsp_valid,
    output cci_req_pkg::t_tag       rsp_tag,
    output cci_req_pkg::t_data      rsp_data
);

    // Internal APB link between issue stage and memory
    logic               psel;
    logic               penable;
    logic               pwrite;
    cci_req_pkg::t_addr paddr;
    cci_req_pkg::t_data pwdata;
    cci_req_pkg::t_data prdata;
    logic               pready;

    cci_tx_if buf_tx ();

    // ========================================
    // Pipeline stages
    // ========================================

    shim_buffer_lockstep
    #(
        .N_ENTRIES(N_ENTRIES),
        .THRESHOLD(THRESHOLD)
    )
    u_buffer
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .c0_valid   (c0_valid),
        .c0_addr    (c0_addr),
        .c0_tag     (c0_tag),
        .c1_valid   (c1_valid),
        .c1_addr    (c1_addr),
        .c1_data    (c1_data),
        .c1_tag     (c1_tag),
        .almost_full(almost_full),
        .buf_tx     (buf_tx.producer)
    );

    req_issue_apb u_issue
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .buf_tx   (buf_tx.consumer),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .rsp_valid(rsp_valid),
        .rsp_tag  (rsp_tag),
        .rsp_data (rsp_data)
    );

    host_mem_apb
    #(
        .MEM_WORDS(MEM_WORDS)
    )
    u_mem
    (
        .clk    (clk),
        .arst_n (arst_n),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready)
    );

endmodule

`default_nettype wire

//--- source/req_issue_apb.sv
/*
 * Takes lockstep entries off the buffer and replays them as APB transfers,
 * read first, then write, returning read data with the request tag
 */
`timescale 1ns/1ns
`default_nettype none

module req_issue_apb
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    cci_tx_if.consumer              buf_tx,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output cci_req_pkg::t_addr      paddr,
    output cci_req_pkg::t_data      pwdata,
    input  cci_req_pkg::t_data      prdata,
    input  wire logic               pready,
    output logic                    rsp_valid,
    output cci_req_pkg::t_tag       rsp_tag,
    output cci_req_pkg::t_data      rsp_data
);

    shim_cfg_pkg::t_issue_state state;
    shim_cfg_pkg::t_issue_state state_next;
    cci_req_pkg::t_xfer_kind    xfer_kind;
    logic                       entry_present;

    // Copy of the dequeued entry, held until both transfers complete
    cci_req_pkg::t_addr         lat_c0_addr;
    cci_req_pkg::t_tag          lat_c0_tag;
    logic                       lat_c1_valid;
    cci_req_pkg::t_addr         lat_c1_addr;
    cci_req_pkg::t_data         lat_c1_data;

    assign entry_present = buf_tx.c0_valid || buf_tx.c1_valid;

    // Entry leaves the buffer in the same cycle the FSM starts on it
    assign buf_tx.deq = (state == shim_cfg_pkg::idle) && entry_present;

    // ========================================
    // Sequencing FSM
    // ========================================

    always_comb
    begin
        state_next = state;
        unique case (state)
            shim_cfg_pkg::idle:
            begin
                // A channel 0 request is always served before channel 1
                if (buf_tx.c0_valid)
                    state_next = shim_cfg_pkg::rd_setup;
                else if (buf_tx.c1_valid)
                    state_next = shim_cfg_pkg::wr_setup;
            end
            shim_cfg_pkg::rd_setup:
                state_next = shim_cfg_pkg::rd_access;
            shim_cfg_pkg::rd_access:
            begin
                // Skip the write phase when the entry carried no write
                if (pready)
                    state_next = lat_c1_valid ? shim_cfg_pkg::wr_setup : shim_cfg_pkg::idle;
            end
            shim_cfg_pkg::wr_setup:
                state_next = shim_cfg_pkg::wr_access;
            shim_cfg_pkg::wr_access:
            begin
                if (pready)
                    state_next = shim_cfg_pkg::idle;
            end
            default:
                state_next = shim_cfg_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= shim_cfg_pkg::idle;
            lat_c1_valid <= 1'b0;
            rsp_valid    <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (buf_tx.deq)
            begin
                lat_c1_valid <= buf_tx.c1_valid;
            end
            // One-cycle pulse when the read transfer completes
            rsp_valid <= (state == shim_cfg_pkg::rd_access) && pready;
        end
    end

    // Payload registers only change on dequeue or read completion
    always_ff @(posedge clk)
    begin
        if (buf_tx.deq)
        begin
            lat_c0_addr <= buf_tx.c0_addr;
            lat_c0_tag  <= buf_tx.c0_tag;
            lat_c1_addr <= buf_tx.c1_addr;
            lat_c1_data <= buf_tx.c1_data;
        end
        if ((state == shim_cfg_pkg::rd_access) && pready)
        begin
            rsp_data <= prdata;
            rsp_tag  <= lat_c0_tag;
        end
    end

    // ========================================
    // APB request outputs
    // ========================================

    // The write states select channel 1, everything else channel 0
    assign xfer_kind = ((state == shim_cfg_pkg::wr_setup) || (state == shim_cfg_pkg::wr_access))
                       ? cci_req_pkg::xfer_write : cci_req_pkg::xfer_read;

    // Address and data come from latched values so they stay stable
    assign psel    = (state != shim_cfg_pkg::idle);
    assign penable = (state == shim_cfg_pkg::rd_access) || (state == shim_cfg_pkg::wr_access);
    assign pwrite  = (xfer_kind == cci_req_pkg::xfer_write);
    assign paddr   = pwrite ? lat_c1_addr : lat_c0_addr;
    assign pwdata  = lat_c1_data;

endmodule

`default_nettype wire

//--- source/shim_buffer_lockstep.sv
/*
 * Holds channel 0 and channel 1 requests together in one FIFO so that
 * reads and writes leave the buffer in the order they arrived
 */
`timescale 1ns/1ns
`default_nettype none

module shim_buffer_lockstep
#(
    parameter int N_ENTRIES = shim_cfg_pkg::DEF_N_ENTRIES,
    parameter int THRESHOLD = shim_cfg_pkg::DEF_THRESHOLD
)
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               c0_valid,
    input  cci_req_pkg::t_addr      c0_addr,
    input  cci_req_pkg::t_tag       c0_tag,
    input  wire logic               c1_valid,
    input  cci_req_pkg::t_addr      c1_addr,
    input  cci_req_pkg::t_data      c1_data,
    input  cci_req_pkg::t_tag       c1_tag,
    output logic                    almost_full,
    cci_tx_if.producer              buf_tx
);

    // One FIFO word holds valid, address and tag of channel 0 followed by
    // valid, address, data and tag of channel 1
    localparam int C0_BITS = 1 + $bits(cci_req_pkg::t_addr) + $bits(cci_req_pkg::t_tag);
    localparam int C1_BITS = 1 + $bits(cci_req_pkg::t_addr) + $bits(cci_req_pkg::t_data)
                             + $bits(cci_req_pkg::t_tag);
    localparam int TX_BITS = C0_BITS + C1_BITS;

    logic               enq_en;
    logic [TX_BITS-1:0] first;
    logic               not_empty;
    logic               head_c0_valid;
    logic               head_c1_valid;

    // An entry exists as soon as either channel carries a request
    assign enq_en = c0_valid || c1_valid;

    // Field order here must match the enq_data concatenation below
    assign {head_c0_valid, buf_tx.c0_addr, buf_tx.c0_tag,
            head_c1_valid, buf_tx.c1_addr, buf_tx.c1_data, buf_tx.c1_tag} = first;

    // Stale storage behind an empty FIFO must never look like a request
    assign buf_tx.c0_valid = head_c0_valid && not_empty;
    assign buf_tx.c1_valid = head_c1_valid && not_empty;

    // Both channels share this one FIFO and therefore one almost-full
    shim_fifo
    #(
        .N_DATA_BITS(TX_BITS),
        .N_ENTRIES  (N_ENTRIES),
        .THRESHOLD  (THRESHOLD)
    )
    u_fifo
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .enq_data   ({c0_valid, c0_addr, c0_tag, c1_valid, c1_addr, c1_data, c1_tag}),
        .enq_en     (enq_en),
        .deq_en     (buf_tx.deq),
        .first      (first),
        .not_empty  (not_empty),
        .almost_full(almost_full)
    );

endmodule

`default_nettype wire

//--- source/shim_cfg_pkg.sv
/*
 * Default sizing of the request buffer and host memory, plus the state
 * encoding of the issue stage
 */
`default_nettype none

package shim_cfg_pkg;

    // Buffer depth and the free-slot count at which almost_full rises
    localparam int DEF_N_ENTRIES = 16;
    localparam int DEF_THRESHOLD = 4;

    // Number of 32-bit words in the host memory model
    localparam int DEF_MEM_WORDS = 256;

    // Issue stage sequencing, read always runs before write
    typedef enum logic [2:0]
    {
        idle,
        rd_setup,
        rd_access,
        wr_setup,
        wr_access
    } t_issue_state;

endpackage

`default_nettype wire

//--- source/shim_fifo.sv
/*
 * Circular FIFO in distributed storage, head visible without a dequeue
 * and a registered almost-full flag driven by a free-slot threshold
 */
`timescale 1ns/1ns
`default_nettype none

module shim_fifo
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = 16,
    parameter int THRESHOLD   = 4
)
(
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic [N_DATA_BITS-1:0] enq_data,
    input  wire logic                   enq_en,
    input  wire logic                   deq_en,
    output logic      [N_DATA_BITS-1:0] first,
    output logic                        not_empty,
    output logic                        almost_full
);

    // A single-entry FIFO still needs a one-bit pointer
    localparam int PTR_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic [CNT_W-1:0]       count_next;

    // ========================================
    // Storage and pointers
    // ========================================

    // Payload is written at the tail pointer on every enqueue
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap explicitly so depths that are not a power of two work
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // ========================================
    // Occupancy and flags
    // ========================================

    // Simultaneous enqueue and dequeue leaves occupancy unchanged
    always_comb
    begin
        count_next = count;
        if (enq_en && !deq_en)
        begin
            count_next = count + 1'b1;
        end
        else if (!enq_en && deq_en)
        begin
            count_next = count - 1'b1;
        end
    end

    // The flag is registered from the next occupancy so it tracks count
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            count       <= count_next;
            almost_full <= (N_ENTRIES - int'(count_next)) <= THRESHOLD;
        end
    end

    // Head is read straight out of storage, so data falls through
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

//--- tests/mem_shim_asserts.sv
/*
 * Concurrent protocol checks, bound into the lockstep buffer and into the
 * APB issue stage; unused inputs are tied low at each bind site
 */
`timescale 1ns/1ns
`default_nettype none

module mem_shim_asserts
#(
    parameter int N_ENTRIES = shim_cfg_pkg::DEF_N_ENTRIES
)
(
    input wire logic               clk,
    input wire logic               arst_n,
    input wire logic               enq_en,
    input wire logic               deq,
    input wire logic               entry_present,
    input wire logic               psel,
    input wire logic               penable,
    input wire logic               pwrite,
    input wire cci_req_pkg::t_addr paddr,
    input wire cci_req_pkg::t_data pwdata,
    input wire logic               pready,
    input wire logic               rsp_valid
);

    // Shadow occupancy rebuilt from the enqueue and dequeue strobes
    int occupancy;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(enq_en) - int'(deq);
    end

    a_no_enq_full: assert property (@(posedge clk) disable iff (!arst_n)
        enq_en |-> (occupancy < N_ENTRIES) || deq)
        else $error("enqueue while the buffer holds %0d entries", occupancy);

    a_deq_present: assert property (@(posedge clk) disable iff (!arst_n)
        deq |-> entry_present)
        else $error("dequeue without an entry present");

    // Request fields hold until the completer signals pready
    a_apb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        psel && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else $error("APB request fields changed before pready");

    a_penable_setup: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(penable) |-> $past(psel))
        else $error("penable rose without a setup cycle");

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held longer than one cycle");

endmodule

// The buffer side has no APB, so those inputs stay low here
bind shim_buffer_lockstep mem_shim_asserts
#(
    .N_ENTRIES(N_ENTRIES)
)
u_buffer_asserts
(
    .clk          (clk),
    .arst_n       (arst_n),
    .enq_en       (enq_en),
    .deq          (buf_tx.deq),
    .entry_present(not_empty),
    .psel         (1'b0),
    .penable      (1'b0),
    .pwrite       (1'b0),
    .paddr        ('0),
    .pwdata       ('0),
    .pready       (1'b0),
    .rsp_valid    (1'b0)
);

// The buffer instance checks dequeue against FIFO occupancy, so both strobes stay low here
bind req_issue_apb mem_shim_asserts u_issue_asserts
(
    .clk          (clk),
    .arst_n       (arst_n),
    .enq_en       (1'b0),
    .deq          (1'b0),
    .entry_present(1'b0),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pready       (pready),
    .rsp_valid    (rsp_valid)
);

`default_nettype wire

//--- tests/mem_shim_golden.txt
// Hex digits: kind(1) c0_valid(1) c0_addr(4) c0_tag(2) c1_valid(1) c1_addr(4) c1_data(8) c1_tag(2)
// Kind 1 request after a random gap, 3 request back to back, 2 response (tag at c0_tag, data at c1_data)
11001001000000000000000
20000001000000000000000
1000000010020DEADBEEF02
11002003000000000000000
2000000300000DEADBEEF00
11003004100301234567805
20000004000000000000000
11003006000000000000000
20000006000001234567800
1000000010040A5A5A5A507
11012008100500BADF00D09
2000000800000DEADBEEF00
1100500A000000000000000
2000000A000000BADF00D00
1100400B000000000000000
2000000B00000A5A5A5A500
31007020100707000000140
31007021100707000000241
31007022100707000000342
31007023100707000000443
31007024100707000000544
31007025100707000000645
31007026100707000000746
31007027100707000000847
31007028100707000000948
31007029100707000000A49
3100702A100707000000B4A
3100702B100707000000C4B
3100702C100707000000D4C
3100702D100707000000E4D
3100702E100707000000F4E
3100702F10070700000104F
20000020000000000000000
20000021000007000000100
20000022000007000000200
20000023000007000000300
20000024000007000000400
20000025000007000000500
20000026000007000000600
20000027000007000000700
20000028000007000000800
20000029000007000000900
2000002A000007000000A00
2000002B000007000000B00
2000002C000007000000C00
2000002D000007000000D00
2000002E000007000000E00
2000002F000007000000F00

//--- tests/mem_shim_tb.sv
/*
 * Testbench for the memory request shim. It replays the request list of the
 * golden file and compares every read response with the golden expectation
 */
`timescale 1ns/1ns
`default_nettype none

module mem_shim_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DLY    = 2;
    localparam int DRAIN_CYCLES = 20;
    localparam int REC_W        = 92;
    localparam int MAX_RECS     = 64;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               c0_valid;
    cci_req_pkg::t_addr c0_addr;
    cci_req_pkg::t_tag  c0_tag;
    logic               c1_valid;
    cci_req_pkg::t_addr c1_addr;
    cci_req_pkg::t_data c1_data;
    cci_req_pkg::t_tag  c1_tag;
    logic               almost_full;
    logic               rsp_valid;
    cci_req_pkg::t_tag  rsp_tag;
    cci_req_pkg::t_data rsp_data;

    // Golden records, split into requests and expected responses on load
    logic [REC_W-1:0]   golden [MAX_RECS];
    logic [REC_W-1:0]   req_q [$];
    cci_req_pkg::t_tag  exp_tag_q [$];
    cci_req_pkg::t_data exp_data_q [$];

    int                 errors = 0;
    int                 rsp_count = 0;
    int                 watchdog_ns = 0;
    logic               af_seen = 1'b0;
    integer             seed = 22;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_shim_top uut
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .c0_valid   (c0_valid),
        .c0_addr    (c0_addr),
        .c0_tag     (c0_tag),
        .c1_valid   (c1_valid),
        .c1_addr    (c1_addr),
        .c1_data    (c1_data),
        .c1_tag     (c1_tag),
        .almost_full(almost_full),
        .rsp_valid  (rsp_valid),
        .rsp_tag    (rsp_tag),
        .rsp_data   (rsp_data)
    );

    // ========================================
    // Helper tasks
    // ========================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h at %0d ns",
                     name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic clear_inputs();
        c0_valid = 1'b0;
        c0_addr  = '0;
        c0_tag   = '0;
        c1_valid = 1'b0;
        c1_addr  = '0;
        c1_data  = '0;
        c1_tag   = '0;
    endtask

    // Record layout, kind [91:88] c0_valid [87:84] c0_addr [83:68] c0_tag [67:60]
    // c1_valid [59:56] c1_addr [55:40] c1_data [39:8] c1_tag [7:0]
    task automatic apply_entry(input logic [REC_W-1:0] rec);
        c0_valid = (rec[87:84] != 4'h0);
        c0_addr  = rec[83:68];
        c0_tag   = rec[67:60];
        c1_valid = (rec[59:56] != 4'h0);
        c1_addr  = rec[55:40];
        c1_data  = rec[39:8];
        c1_tag   = rec[7:0];
    endtask

    // Kind 1 and 3 are requests, kind 2 an expected response, 0 is unused space
    task automatic load_golden();
        logic [3:0] kind;
        for (int i = 0; i < MAX_RECS; i++)
            golden[i] = '0;
        $readmemh("tests/mem_shim_golden.txt", golden);
        for (int i = 0; i < MAX_RECS; i++)
        begin
            kind = golden[i][91:88];
            if ((kind == 4'h1) || (kind == 4'h3))
            begin
                req_q.push_back(golden[i]);
            end
            else if (kind == 4'h2)
            begin
                exp_tag_q.push_back(golden[i][67:60]);
                exp_data_q.push_back(golden[i][39:8]);
            end
            else if (kind != 4'h0)
            begin
                $display("golden record %0d has an unknown kind %0h", i, kind);
                errors++;
            end
        end
        if (req_q.size() == 0)
        begin
            $display("the golden file held no request records");
            errors++;
        end
    endtask

    // Entered 2 ns after a rising edge and returns at the same point of a later cycle
    task automatic send_entry(input logic [REC_W-1:0] rec);
        int gap;
        gap = 0;
        clear_inputs();
        if (rec[91:88] == 4'h1)
            gap = $unsigned($random(seed)) % 3;
        repeat (gap)
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        // The buffer has no ready, so the driver itself honours almost_full
        while (almost_full)
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        apply_entry(rec);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // ========================================
    // Stimulus, monitor and watchdog
    // ========================================

    initial
    begin
        clear_inputs();
        arst_n = 1'b0;
        load_golden();
        watchdog_ns = req_q.size() * 2 * 3 * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        check_value("almost_full", 32'h0, almost_full);
        check_value("rsp_valid", 32'h0, rsp_valid);
        foreach (req_q[i])
            send_entry(req_q[i]);
        clear_inputs();
        wait (rsp_count >= exp_tag_q.size());
        // Extra window so that a surplus response is still caught
        repeat (DRAIN_CYCLES) @(posedge clk);
        check_value("almost_full_seen", 32'h1, af_seen);
        $display("errors=%0d responses=%0d expected=%0d", errors, rsp_count, exp_tag_q.size());
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Outputs settle well before the falling edge, a pulse is seen exactly once
    always @(negedge clk)
    begin
        if (almost_full)
            af_seen = 1'b1;
        if (arst_n && rsp_valid)
        begin
            if (rsp_count < exp_tag_q.size())
            begin
                check_value("rsp_tag", exp_tag_q[rsp_count], rsp_tag);
                check_value("rsp_data", exp_data_q[rsp_count], rsp_data);
            end
            else
            begin
                $display("an extra response with tag 0x%0h arrived", rsp_tag);
                errors++;
            end
            rsp_count++;
        end
    end

    initial
    begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("timeout after %0d ns, expected responses did not arrive", watchdog_ns);
        errors++;
        $display("errors=%0d responses=%0d expected=%0d", errors, rsp_count, exp_tag_q.size());
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
